//--- list.f
+incdir+include
hw/rob_pkg.sv
hw/rob_ifs.sv
hw/rob_ptrs.sv
hw/rob_queue.sv
hw/rrf.sv
hw/recovery_fsm.sv
hw/rob_top.sv
bench/tb_clk.sv
bench/rob_sva.sv
bench/rob_tb.sv

//--- run.sh
#!/bin/sh
# build and run the reorder buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module rob_tb -o rob_sim

./obj_dir/rob_sim > sim.log 2>&1
cat sim.log

# pass only if the testbench printed its pass line
grep -q "^Test OK$" sim.log

//--- bench/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_tb import rob_pkg::*; ();

    localparam int TEST_CYCLES = 400;

    logic clk, rst;
    logic disp_valid, disp_we;
    arch_t disp_arch;
    phys_t disp_phys;
    logic [31:0] disp_pc;
    logic cdb0_valid, cdb0_mispredict, cdb1_valid, cdb1_mispredict;
    rob_idx_t cdb0_idx, cdb1_idx;
    logic [31:0] cdb0_result, cdb0_target, cdb1_result, cdb1_target;
    logic dispatch_ready, commit_valid, commit_we, redirect_valid;
    rob_idx_t dispatch_idx;
    arch_t commit_arch;
    phys_t commit_phys, freed_phys;
    logic [31:0] commit_pc, commit_result, redirect_pc;

    // reference model
    arch_t e_arch [`ROB_DEPTH];
    phys_t e_phys [`ROB_DEPTH];
    logic e_we [`ROB_DEPTH];
    logic e_done [`ROB_DEPTH];
    logic e_mis [`ROB_DEPTH];
    logic [31:0] e_pc [`ROB_DEPTH];
    logic [31:0] e_result [`ROB_DEPTH];
    logic [31:0] e_target [`ROB_DEPTH];
    int e_ccyc [`ROB_DEPTH];
    phys_t map [32];
    rob_idx_t order [$];   // dispatch order of uncommitted entries
    rob_idx_t undone [$];  // dispatched but not yet completed
    rob_idx_t exp_head, exp_tail;
    logic [31:0] lfsr = 32'h428f9287;
    logic [31:0] pc_next = 32'h1000;
    int cyc, errors, passed, failed;

    tb_clk clk_i (.clk(clk), .rst(rst));

    rob_top dut_i (.*);

    function automatic logic [31:0] get_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s", msg);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s: %0d errors", name, errors - err_before);
        if (errors == err_before) passed++;
        else failed++;
    endtask

    // commit checker
    always @(negedge clk) begin
        rob_idx_t i;
        if (!rst) begin
            if (commit_valid) begin
                if (order.size() == 0) begin
                    check_true(1'b0, "commit seen with no entry outstanding");
                end else begin
                    i = order.pop_front();
                    check_val("commit_pc", commit_pc, e_pc[i]);
                    check_val("commit_arch", 32'(commit_arch), 32'(e_arch[i]));
                    check_val("commit_phys", 32'(commit_phys), 32'(e_phys[i]));
                    check_val("commit_we", 32'(commit_we), 32'(e_we[i]));
                    check_val("commit_result", commit_result, e_result[i]);
                    check_true(e_done[i] && cyc > e_ccyc[i], "commit came before its completion");
                    check_val("freed_phys", 32'(freed_phys), 32'(map[e_arch[i]]));
                    check_val("redirect_valid", 32'(redirect_valid), 32'(e_mis[i]));
                    if (e_we[i]) map[e_arch[i]] = e_phys[i];
                    exp_head++;
                    if (e_mis[i]) begin
                        check_val("redirect_pc", redirect_pc, e_target[i]);
                        order.delete();   // younger entries are gone
                        undone.delete();
                        exp_tail = exp_head;
                    end
                end
            end else begin
                check_val("redirect_valid", 32'(redirect_valid), 32'd0);
            end
            cyc++;
        end
    end

    task automatic dispatch_one(input arch_t arch, input phys_t phys, input logic we,
                                output rob_idx_t idx);
        int waited;
        @(posedge clk);
        disp_valid <= 1'b1;
        disp_arch  <= arch;
        disp_phys  <= phys;
        disp_we    <= we;
        disp_pc    <= pc_next;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!dispatch_ready && waited < 50);
        idx = dispatch_idx;
        if (!dispatch_ready) begin
            check_true(1'b0, "dispatch was never accepted");
        end else begin
            check_val("dispatch_idx", 32'(idx), 32'(exp_tail));
            e_arch[idx] = arch;
            e_phys[idx] = phys;
            e_we[idx]   = we;
            e_pc[idx]   = pc_next;
            e_done[idx] = 1'b0;
            e_mis[idx]  = 1'b0;
            order.push_back(idx);
            undone.push_back(idx);
            exp_tail++;
            pc_next += 4;
        end
        @(posedge clk);   // accept edge
        disp_valid <= 1'b0;
    endtask

    task automatic set_lane(input logic lane, input rob_idx_t idx, input logic mis,
                            input logic [31:0] target);
        logic [31:0] res;
        res = get_bits(32);
        if (!lane) begin
            cdb0_valid <= 1'b1;
            cdb0_idx <= idx;
            cdb0_result <= res;
            cdb0_mispredict <= mis;
            cdb0_target <= target;
        end else begin
            cdb1_valid <= 1'b1;
            cdb1_idx <= idx;
            cdb1_result <= res;
            cdb1_mispredict <= mis;
            cdb1_target <= target;
        end
        e_result[idx] = res;
        e_done[idx]   = 1'b1;
        e_mis[idx]    = mis;
        e_target[idx] = target;
        e_ccyc[idx]   = cyc;
        for (int k = 0; k < undone.size(); k++) begin
            if (undone[k] == idx) begin
                undone.delete(k);
                break;
            end
        end
    endtask

    task automatic clear_lanes();
        cdb0_valid <= 1'b0;
        cdb1_valid <= 1'b0;
        cdb0_mispredict <= 1'b0;
        cdb1_mispredict <= 1'b0;
    endtask

    task automatic complete_idx(input rob_idx_t idx, input logic lane, input logic mis,
                                input logic [31:0] target);
        @(posedge clk);
        set_lane(lane, idx, mis, target);
        @(posedge clk);
        clear_lanes();
    endtask

    task automatic wait_empty(input int limit);
        int w;
        w = 0;
        while (order.size() != 0 && w < limit) begin
            @(posedge clk);
            w++;
        end
        check_true(order.size() == 0, "buffer did not drain in time");
    endtask

    // complete whatever is outstanding in random order on random lanes
    task automatic drain();
        int k;
        while (undone.size() > 0) begin
            k = int'(get_bits(8)) % undone.size();
            complete_idx(undone[k], get_bits(1) != 0, 1'b0, 32'h0);
        end
        wait_empty(100);
    endtask

    initial begin
        #(TEST_CYCLES * 4 * 8);
        $display("watchdog expired after %0d cycles", TEST_CYCLES * 4);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int err0, w;
        rob_idx_t a, b, c, d;
        disp_valid = 0;
        disp_we = 0;
        disp_arch = '0;
        disp_phys = '0;
        disp_pc = '0;
        cdb0_valid = 0;
        cdb0_idx = '0;
        cdb0_result = '0;
        cdb0_mispredict = 0;
        cdb0_target = '0;
        cdb1_valid = 0;
        cdb1_idx = '0;
        cdb1_result = '0;
        cdb1_mispredict = 0;
        cdb1_target = '0;
        for (int i = 0; i < 32; i++) map[i] = phys_t'(i);
        exp_head = '0;
        exp_tail = '0;
        wait (!rst);

        err0 = errors;   // in-order commit
        @(negedge clk);
        check_val("dispatch_ready", 32'(dispatch_ready), 32'd1);
        for (int n = 0; n < 10; n++) begin
            dispatch_one(arch_t'(get_bits(5)), phys_t'(32 + n), get_bits(1) != 0, a);
        end
        drain();
        report_test("in_order_commit", err0);

        err0 = errors;   // back-pressure
        for (int n = 0; n < `ROB_DEPTH; n++) begin
            dispatch_one(arch_t'(n), phys_t'(n + 16), 1'b1, a);
        end
        @(negedge clk);
        check_val("dispatch_ready", 32'(dispatch_ready), 32'd0);
        @(posedge clk);
        disp_valid <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_val("dispatch_ready", 32'(dispatch_ready), 32'd0);
            check_val("dispatch_idx", 32'(dispatch_idx), 32'(exp_tail));
        end
        @(posedge clk);
        disp_valid <= 1'b0;
        complete_idx(order[0], 1'b0, 1'b0, 32'h0);
        @(negedge clk);
        check_val("commit_valid", 32'(commit_valid), 32'd1);
        check_val("dispatch_ready", 32'(dispatch_ready), 32'd0);
        @(negedge clk);
        check_val("dispatch_ready", 32'(dispatch_ready), 32'd1);
        drain();
        report_test("back_pressure", err0);

        err0 = errors;   // freed tags over a few reused registers
        for (int n = 0; n < 8; n++) begin
            dispatch_one(arch_t'(1 + int'(get_bits(8)) % 3), phys_t'(40 + n),
                         get_bits(1) != 0, a);
        end
        drain();
        report_test("freed_tags", err0);

        err0 = errors;   // mispredict recovery
        dispatch_one(arch_t'(5), phys_t'(50), 1'b1, a);
        dispatch_one(arch_t'(0), phys_t'(51), 1'b0, b);
        dispatch_one(arch_t'(6), phys_t'(52), 1'b1, c);
        dispatch_one(arch_t'(7), phys_t'(53), 1'b1, d);
        complete_idx(c, 1'b0, 1'b0, 32'h0);
        complete_idx(d, 1'b1, 1'b0, 32'h0);
        complete_idx(b, 1'b1, 1'b1, 32'h0000_8000);
        complete_idx(a, 1'b0, 1'b0, 32'h0);
        w = 0;
        do begin
            @(negedge clk);
            w++;
        end while (!redirect_valid && w < 50);
        check_true(redirect_valid, "mispredicted branch never redirected");
        check_val("dispatch_ready", 32'(dispatch_ready), 32'd0);   // redirect cycle
        repeat (`RECOVER_CYCLES) begin
            @(negedge clk);
            check_val("dispatch_ready", 32'(dispatch_ready), 32'd0);
        end
        @(negedge clk);
        check_val("dispatch_ready", 32'(dispatch_ready), 32'd1);
        check_val("dispatch_idx", 32'(dispatch_idx), 32'(rob_idx_t'(b + 1'b1)));
        dispatch_one(arch_t'(8), phys_t'(54), 1'b1, a);
        drain();
        report_test("mispredict_recovery", err0);

        err0 = errors;   // both lanes in one cycle
        dispatch_one(arch_t'(9), phys_t'(55), 1'b1, a);
        dispatch_one(arch_t'(10), phys_t'(56), 1'b1, b);
        @(posedge clk);
        set_lane(1'b0, b, 1'b0, 32'h0);
        set_lane(1'b1, a, 1'b0, 32'h0);
        @(posedge clk);
        clear_lanes();
        wait_empty(20);
        report_test("dual_completion", err0);

        errors += dut_i.sva_i.fail_count;   // bound assertion failures
        $display("tests passed %0d failed %0d errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/rob_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_sva (
    input wire logic clk,
    input wire logic rst,
    input wire logic commit_valid,
    input wire logic redirect_valid,
    input wire logic dispatch_ready,
    input wire logic empty
);

    logic [3:0] stall_left;   // recovery cycles still owed
    int         fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_left <= '0;
        end else if (redirect_valid) begin
            stall_left <= 4'(`RECOVER_CYCLES);
        end else if (stall_left != '0) begin
            stall_left <= stall_left - 1'b1;
        end
    end

    flush_empties_buffer: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !commit_valid)
        else begin
            $error("commit in the cycle after a flush");
            fail_count++;
        end

    empty_never_commits: assert property (@(posedge clk) disable iff (rst)
        empty |-> !commit_valid)
        else begin
            $error("commit from an empty buffer");
            fail_count++;
        end

    stall_holds_ready_low: assert property (@(posedge clk) disable iff (rst)
        stall_left != '0 |-> !dispatch_ready)
        else begin
            $error("dispatch ready during recovery");
            fail_count++;
        end

    ready_after_stall: assert property (@(posedge clk) disable iff (rst)
        stall_left == 4'd1 |=> dispatch_ready)
        else begin
            $error("dispatch ready did not return after recovery");
            fail_count++;
        end

    no_commit_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !commit_valid)
        else begin
            $error("commit in the first cycle after reset");
            fail_count++;
        end

endmodule

bind rob_top rob_sva sva_i (
    .clk            (clk),
    .rst            (rst),
    .commit_valid   (commit_valid),
    .redirect_valid (redirect_valid),
    .dispatch_ready (dispatch_ready),
    .empty          (empty)
);

`default_nettype wire

//--- bench/tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- hw/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top import rob_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,

    // dispatch
    input  wire logic         disp_valid,
    input  arch_t             disp_arch,
    input  phys_t             disp_phys,
    input  wire logic         disp_we,
    input  wire logic [31:0]  disp_pc,

    // completion lanes
    input  wire logic         cdb0_valid,
    input  rob_idx_t          cdb0_idx,
    input  wire logic [31:0]  cdb0_result,
    input  wire logic         cdb0_mispredict,
    input  wire logic [31:0]  cdb0_target,
    input  wire logic         cdb1_valid,
    input  rob_idx_t          cdb1_idx,
    input  wire logic [31:0]  cdb1_result,
    input  wire logic         cdb1_mispredict,
    input  wire logic [31:0]  cdb1_target,

    output logic              dispatch_ready,
    output rob_idx_t          dispatch_idx,

    // retirement
    output logic              commit_valid,
    output arch_t             commit_arch,
    output phys_t             commit_phys,
    output logic              commit_we,
    output logic [31:0]       commit_pc,
    output logic [31:0]       commit_result,
    output phys_t             freed_phys,

    output logic              redirect_valid,
    output logic [31:0]       redirect_pc
);

    logic        push;
    logic        flush;
    logic        full;
    logic        empty;   // observed by the bound checker
    rob_idx_t    head_idx;
    rob_idx_t    tail_idx;
    logic        commit_mispredict;
    logic [31:0] commit_target;

    dispatch_if disp_bus ();
    cdb_if      cdb0_bus ();
    cdb_if      cdb1_bus ();

    assign disp_bus.valid = disp_valid;
    assign disp_bus.arch  = disp_arch;
    assign disp_bus.phys  = disp_phys;
    assign disp_bus.we    = disp_we;
    assign disp_bus.pc    = disp_pc;

    assign cdb0_bus.valid      = cdb0_valid;
    assign cdb0_bus.idx        = cdb0_idx;
    assign cdb0_bus.result     = cdb0_result;
    assign cdb0_bus.mispredict = cdb0_mispredict;
    assign cdb0_bus.target     = cdb0_target;

    assign cdb1_bus.valid      = cdb1_valid;
    assign cdb1_bus.idx        = cdb1_idx;
    assign cdb1_bus.result     = cdb1_result;
    assign cdb1_bus.mispredict = cdb1_mispredict;
    assign cdb1_bus.target     = cdb1_target;

    assign dispatch_idx = tail_idx;   // slot the next accepted dispatch gets

    rob_ptrs ptrs_i (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .pop      (commit_valid),
        .flush    (flush),
        .head_idx (head_idx),
        .tail_idx (tail_idx),
        .full     (full),
        .empty    (empty)
    );

    rob_queue queue_i (
        .clk               (clk),
        .rst               (rst),
        .disp              (disp_bus.sink),
        .cdb0              (cdb0_bus.sink),
        .cdb1              (cdb1_bus.sink),
        .dispatch_ready    (dispatch_ready),
        .head_idx          (head_idx),
        .tail_idx          (tail_idx),
        .flush             (flush),
        .push              (push),
        .commit_valid      (commit_valid),
        .commit_mispredict (commit_mispredict),
        .commit_arch       (commit_arch),
        .commit_phys       (commit_phys),
        .commit_we         (commit_we),
        .commit_pc         (commit_pc),
        .commit_result     (commit_result),
        .commit_target     (commit_target)
    );

    rrf rrf_i (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit_we    (commit_we),
        .commit_arch  (commit_arch),
        .commit_phys  (commit_phys),
        .freed_phys   (freed_phys)
    );

    recovery_fsm recovery_i (
        .clk               (clk),
        .rst               (rst),
        .full              (full),
        .commit_valid      (commit_valid),
        .commit_mispredict (commit_mispredict),
        .commit_target     (commit_target),
        .dispatch_ready    (dispatch_ready),
        .flush             (flush),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc)
    );

endmodule

`default_nettype wire

//--- hw/recovery_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module recovery_fsm import rob_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         full,
    input  wire logic         commit_valid,
    input  wire logic         commit_mispredict,
    input  wire logic [31:0]  commit_target,
    output logic              dispatch_ready,
    output logic              flush,
    output logic              redirect_valid,
    output logic [31:0]       redirect_pc
);

    localparam int CNT_W = $clog2(`RECOVER_CYCLES + 1);

    rec_state_t       state;
    logic [CNT_W-1:0] cnt;   // stall cycles left after this one

    // the buffer is empty while recovering, so no commit there
    assign redirect_valid = (state == RUN) && commit_valid && commit_mispredict;
    assign flush          = redirect_valid;
    assign redirect_pc    = commit_target;

    // a dispatch in the redirect cycle would land behind the flush
    assign dispatch_ready = (state == RUN) && !full && !redirect_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RUN;
            cnt   <= '0;
        end else begin
            case (state)
                RUN: begin
                    if (redirect_valid) begin
                        state <= RECOVER;
                        cnt   <= CNT_W'(`RECOVER_CYCLES - 1);
                    end
                end
                RECOVER: begin
                    if (cnt == '0) begin
                        state <= RUN;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= RUN;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/rrf.sv
`timescale 1ns/1ps
`default_nettype none

module rrf import rob_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  commit_valid,
    input  wire logic  commit_we,
    input  arch_t      commit_arch,
    input  phys_t      commit_phys,
    output phys_t      freed_phys
);

    localparam int NUM_ARCH = 2 ** $bits(arch_t);

    // committed arch to phys mapping
    phys_t map [NUM_ARCH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                map[i] <= phys_t'(i);   // identity after reset
            end
        end else if (commit_valid && commit_we) begin
            map[commit_arch] <= commit_phys;
        end
    end

    // old tag goes back to the free list
    assign freed_phys = map[commit_arch];

endmodule

`default_nettype wire

//--- hw/rob_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_queue import rob_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,

    dispatch_if.sink   disp,
    cdb_if.sink        cdb0,
    cdb_if.sink        cdb1,

    input  wire logic  dispatch_ready,
    input  rob_idx_t   head_idx,
    input  rob_idx_t   tail_idx,
    input  wire logic  flush,

    output logic        push,
    output logic        commit_valid,
    output logic        commit_mispredict,
    output arch_t       commit_arch,
    output phys_t       commit_phys,
    output logic        commit_we,
    output logic [31:0] commit_pc,
    output logic [31:0] commit_result,
    output logic [31:0] commit_target
);

    rob_entry_t mem [`ROB_DEPTH];
    rob_entry_t head;

    // ready is registered state only, a full buffer refuses even while committing
    assign push = disp.valid && dispatch_ready;

    always_ff @(posedge clk) begin
        // new entry at the tail
        if (push) begin
            mem[tail_idx].done       <= 1'b0;
            mem[tail_idx].mispredict <= 1'b0;
            mem[tail_idx].arch       <= disp.arch;
            mem[tail_idx].phys       <= disp.phys;
            mem[tail_idx].we         <= disp.we;
            mem[tail_idx].pc         <= disp.pc;
        end

        // lane 0 writeback
        if (cdb0.valid) begin
            mem[cdb0.idx].done   <= 1'b1;
            mem[cdb0.idx].result <= cdb0.result;
            if (cdb0.mispredict) begin
                mem[cdb0.idx].mispredict <= 1'b1;
                mem[cdb0.idx].target     <= cdb0.target;
            end
        end

        // lane 1 writeback, never the same index as lane 0
        if (cdb1.valid) begin
            mem[cdb1.idx].done   <= 1'b1;
            mem[cdb1.idx].result <= cdb1.result;
            if (cdb1.mispredict) begin
                mem[cdb1.idx].mispredict <= 1'b1;
                mem[cdb1.idx].target     <= cdb1.target;
            end
        end

        // occupancy
        if (rst || flush) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                mem[i].valid <= 1'b0;
            end
        end else begin
            if (commit_valid) begin
                mem[head_idx].valid <= 1'b0;
            end
            if (push) begin
                mem[tail_idx].valid <= 1'b1;   // tail != head unless empty
            end
        end
    end

    assign head = mem[head_idx];

    // head retires as soon as it is done
    assign commit_valid      = head.valid && head.done;
    assign commit_mispredict = head.mispredict;
    assign commit_arch       = head.arch;
    assign commit_phys       = head.phys;
    assign commit_we         = head.we;
    assign commit_pc         = head.pc;
    assign commit_result     = head.result;
    assign commit_target     = head.target;

endmodule

`default_nettype wire

//--- hw/rob_ptrs.sv
`timescale 1ns/1ps
`default_nettype none

module rob_ptrs import rob_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     push,
    input  wire logic     pop,
    input  wire logic     flush,
    output rob_idx_t      head_idx,
    output rob_idx_t      tail_idx,
    output logic          full,
    output logic          empty
);

    localparam int IDX_W = $bits(rob_idx_t);

    // msb is the wrap bit
    logic [IDX_W:0] head_q;
    logic [IDX_W:0] tail_q;
    logic [IDX_W:0] head_d;
    logic [IDX_W:0] tail_d;

    always_comb begin
        head_d = head_q + (IDX_W+1)'(pop);
        // flush drops everything behind the committing head
        tail_d = flush ? head_d : tail_q + (IDX_W+1)'(push);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_d;
            tail_q <= tail_d;
        end
    end

    assign head_idx = head_q[IDX_W-1:0];
    assign tail_idx = tail_q[IDX_W-1:0];

    assign empty = (head_q == tail_q);
    assign full  = (head_q[IDX_W-1:0] == tail_q[IDX_W-1:0])
                && (head_q[IDX_W] != tail_q[IDX_W]);   // same slot, one lap apart

endmodule

`default_nettype wire

//--- hw/rob_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// rename/dispatch into the buffer
interface dispatch_if import rob_pkg::*; ();
    logic        valid;
    arch_t       arch;
    phys_t       phys;
    logic        we;
    logic [31:0] pc;

    modport source (output valid, arch, phys, we, pc);
    modport sink   (input  valid, arch, phys, we, pc);
endinterface

// one completion lane
interface cdb_if import rob_pkg::*; ();
    logic        valid;
    rob_idx_t    idx;
    logic [31:0] result;
    logic        mispredict;
    logic [31:0] target;

    modport source (output valid, idx, result, mispredict, target);
    modport sink   (input  valid, idx, result, mispredict, target);
endinterface

`default_nettype wire

//--- hw/rob_pkg.sv
`default_nettype none

`include "rob_defs.svh"

package rob_pkg;

    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;
    typedef logic [`PHYS_W-1:0]            phys_t;
    typedef logic [`ARCH_W-1:0]            arch_t;

    typedef struct packed {
        logic        valid;
        logic        done;       // result written back
        logic        mispredict;
        arch_t       arch;
        phys_t       phys;
        logic        we;
        logic [31:0] pc;
        logic [31:0] result;
        logic [31:0] target;     // only meaningful with mispredict
    } rob_entry_t;

    // recovery controller
    typedef enum logic {
        RUN,
        RECOVER
    } rec_state_t;

endpackage

`default_nettype wire

//--- include/rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// buffer entries, keep a power of two
`define ROB_DEPTH 16

`define PHYS_W 6
`define ARCH_W 5

// dispatch stall after a flush
`define RECOVER_CYCLES 2

`endif
